/* sbuf.f */
hw/sbuf_pkg.sv
hw/ram_port_if.sv
hw/ram_sdp.sv
hw/sbuf_write_ctrl.sv
hw/sbuf_read_ctrl.sv
hw/sbuf_top.sv
tests/sbuf_top_tb.sv

/* Bender.yml */
# Credit-controlled stream buffer

package:
  name: sbuf

sources:
  # Package and interface first, then the RAM, controllers and top level
  - hw/sbuf_pkg.sv
  - hw/ram_port_if.sv
  - hw/ram_sdp.sv
  - hw/sbuf_write_ctrl.sv
  - hw/sbuf_read_ctrl.sv
  - hw/sbuf_top.sv

  # Testbench, top module sbuf_top_tb
  - target: test
    files:
      - tests/sbuf_top_tb.sv

/* tests/sbuf_top_tb.sv */
// Stream buffer testbench

`timescale 1ns/10ps

module sbuf_top_tb;
  import sbuf_pkg::*;

  // Words pushed through the buffer, back-pressure stretch starts halfway
  localparam int NUM_WORDS = 2000;
  localparam int STALL_AT  = 1000;

  // Values a wait loop can watch
  localparam int W_IN_CREDITS = 0;
  localparam int W_SENT       = 1;
  localparam int W_SINK_OWED  = 2;
  localparam int W_STORED     = 3;
  localparam int W_UP_BAL     = 4;

  logic  clk = 1'b0;
  logic  rst_n;
  logic  in_valid;
  data_t in_data;
  logic  in_credit;
  logic  out_credit;
  logic  out_valid;
  data_t out_data;

  // Stimulus controls, changed on the rising edge only
  logic send_en;
  logic grant_en;
  logic grant_free;

  // Model counters, all updated on the falling edge
  int    up_rcvd      = 0;
  int    up_sent      = 0;
  int    sink_granted = 0;
  int    out_seen     = 0;
  data_t ref_q[$];

  int          data_errs  = 0;
  int          count_errs = 0;
  int          flag_errs  = 0;
  int          other_errs = 0;
  int          stall_len;
  int          valid_base;
  int          credit_base;
  logic [31:0] lfsr_state = 32'h5c0f8e43;

  sbuf_top i_sbuf_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_data   (out_data)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // --------------------------------------------------------------------------
  // Random bits and count helpers
  // --------------------------------------------------------------------------

  // Galois step, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end else begin
      return s >> 1;
    end
  endfunction

  // One LFSR step per bit taken
  function automatic data_t rand_bits(input int n);
    data_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[SBUF_DATA_W-2:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // Legal credit balance, nearest value inside 0 to SBUF_DEPTH
  function automatic credit_cnt_t clamp_cnt(input int v);
    if (v < 0) return '0;
    if (v > SBUF_DEPTH) return credit_cnt_t'(SBUF_DEPTH);
    return credit_cnt_t'(v);
  endfunction

  // Anything the type cannot hold shows as all ones
  function automatic credit_cnt_t sat_cnt(input int v);
    if (v < 0 || v > 2**$bits(credit_cnt_t) - 1) return '1;
    return credit_cnt_t'(v);
  endfunction

  function automatic int watch_value(input int sel);
    case (sel)
      W_IN_CREDITS: return up_rcvd;
      W_SENT:       return up_sent;
      W_SINK_OWED:  return sink_granted - out_seen;
      W_STORED:     return ref_q.size();
      W_UP_BAL:     return up_rcvd - up_sent;
      default:      return 0;
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // Compare tasks and bounded wait
  // --------------------------------------------------------------------------

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      data_errs++;
    end
  endtask

  task automatic check_count(input string name, input credit_cnt_t exp,
                             input credit_cnt_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      count_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      flag_errs++;
    end
  endtask

  task automatic wait_for_value(input int sel, input int target, input int limit,
                                input string what);
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (watch_value(sel) != target && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (watch_value(sel) != target) begin
      $display("Timeout at %0t after %0d cycles waiting for %s", $time, limit, what);
      other_errs++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Sender and sink models
  // --------------------------------------------------------------------------

  // Sender spends only credits it holds, sink never owes more than the depth
  always @(posedge clk) begin
    if (send_en && up_sent < NUM_WORDS && up_rcvd - up_sent > 0 &&
        rand_bits(2) != '0) begin
      in_valid <= 1'b1;
      in_data  <= rand_bits(SBUF_DATA_W);
    end else begin
      in_valid <= 1'b0;
    end
    if (grant_en && sink_granted - out_seen < SBUF_DEPTH &&
        (grant_free || rand_bits(1) != '0)) begin
      out_credit <= 1'b1;
    end else begin
      out_credit <= 1'b0;
    end
  end

  // Monitor on the falling edge where every port is settled
  always @(negedge clk) begin
    if (!rst_n) begin
      check_flag("out_valid", 1'b0, out_valid);
      check_flag("in_credit", 1'b0, in_credit);
    end else begin
      if (in_credit) up_rcvd++;
      if (out_credit) sink_granted++;
      if (in_valid) begin
        up_sent++;
        ref_q.push_back(in_data);
      end
      if (out_valid) begin
        out_seen++;
        if (ref_q.size() == 0) begin
          $display("Word on out_data at %0t while no word was pending", $time);
          other_errs++;
        end else begin
          check_data("out_data", ref_q.pop_front(), out_data);
        end
      end
      // Both credit balances must stay within 0 to SBUF_DEPTH
      check_count("sink_credit_balance", clamp_cnt(sink_granted - out_seen),
                  sat_cnt(sink_granted - out_seen));
      check_count("up_credit_balance", clamp_cnt(up_rcvd - up_sent),
                  sat_cnt(up_rcvd - up_sent));
    end
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_data    = '0;
    out_credit = 1'b0;
    send_en    = 1'b0;
    grant_en   = 1'b0;
    grant_free = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // Idle sender sees one credit per slot and nothing more
    wait_for_value(W_IN_CREDITS, SBUF_DEPTH, 100, "startup credits");
    repeat (50) @(posedge clk);
    check_count("in_credit_cnt", credit_cnt_t'(SBUF_DEPTH), sat_cnt(up_rcvd));

    // Random traffic on both sides
    send_en  <= 1'b1;
    grant_en <= 1'b1;
    wait_for_value(W_SENT, STALL_AT, 20 * STALL_AT, "words sent before the stall");

    // Sink withholds credits until the buffer is full
    grant_en <= 1'b0;
    wait_for_value(W_SINK_OWED, 0, 200, "sink credits to be used up");
    wait_for_value(W_STORED, SBUF_DEPTH, 300, "buffer to fill");
    valid_base  = out_seen;
    credit_base = up_rcvd;
    @(negedge clk);
    stall_len = 100 + int'(rand_bits(7));
    repeat (stall_len) @(posedge clk);
    check_count("stored_words", credit_cnt_t'(SBUF_DEPTH), sat_cnt(ref_q.size()));
    check_count("out_valid_cnt", '0, sat_cnt(out_seen - valid_base));
    check_count("in_credit_cnt", '0, sat_cnt(up_rcvd - credit_base));
    grant_en <= 1'b1;

    // Finish sending, then drain with the sink granting every cycle
    wait_for_value(W_SENT, NUM_WORDS, 40 * NUM_WORDS, "all words sent");
    send_en    <= 1'b0;
    grant_free <= 1'b1;
    wait_for_value(W_STORED, 0, 500, "buffer to drain");
    wait_for_value(W_UP_BAL, SBUF_DEPTH, 100, "upstream credits to return");
    repeat (20) @(posedge clk);
    check_count("up_credit_balance", credit_cnt_t'(SBUF_DEPTH), sat_cnt(up_rcvd - up_sent));

    $display("Errors: data %0d, count %0d, flag %0d, other %0d (words out %0d)",
             data_errs, count_errs, flag_errs, other_errs, out_seen);
    if (data_errs + count_errs + flag_errs + other_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* hw/sbuf_top.sv */
// Credit-controlled stream buffer top

`timescale 1ns/10ps

module sbuf_top (
  input  logic            clk,
  input  logic            rst_n,
  // Upstream side
  input  logic            in_valid,
  input  sbuf_pkg::data_t in_data,
  output logic            in_credit,
  // Downstream side
  input  logic            out_credit,
  output logic            out_valid,
  output sbuf_pkg::data_t out_data
);
  import sbuf_pkg::*;

  // Words committed, seen by the reader
  ptr_t wr_ptr;

  // Read issued, credit goes back upstream
  logic slot_freed;

  // --------------------------------------------------------------------------
  // RAM and its ports
  // --------------------------------------------------------------------------

  ram_port_if ram_bus ();

  ram_sdp #(
    .DATA_WIDTH (SBUF_DATA_W),
    .ADDR_WIDTH (SBUF_ADDR_W)
  ) i_ram_sdp (
    .clk (clk),
    .mem (ram_bus.mem)
  );

  // --------------------------------------------------------------------------
  // Controllers
  // --------------------------------------------------------------------------

  sbuf_write_ctrl i_sbuf_write_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_credit  (in_credit),
    .slot_freed (slot_freed),
    .wr_ptr     (wr_ptr),
    .ram        (ram_bus.write_side)
  );

  sbuf_read_ctrl i_sbuf_read_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .wr_ptr     (wr_ptr),
    .slot_freed (slot_freed),
    .ram        (ram_bus.read_side)
  );

endmodule

/* hw/sbuf_read_ctrl.sv */
// Stream buffer read controller

`timescale 1ns/10ps

module sbuf_read_ctrl (
  input  logic            clk,
  input  logic            rst_n,
  // Downstream sink
  input  logic            out_credit,
  output logic            out_valid,
  output sbuf_pkg::data_t out_data,
  // Shared with the write controller
  input  sbuf_pkg::ptr_t  wr_ptr,
  output logic            slot_freed,
  // RAM read port
  ram_port_if.read_side   ram
);
  import sbuf_pkg::*;

  // Next slot to read, wrap bit included
  ptr_t        rd_ptr;

  // Downstream credits held and not yet spent
  credit_cnt_t cred_cnt;

  // Words stored and not yet read
  logic        has_word;

  // A credit is available, counting one arriving this cycle
  logic        has_credit;

  // Read issued this cycle
  logic        rd_issue;

  // --------------------------------------------------------------------------
  // Issue decision
  // --------------------------------------------------------------------------

  assign has_word   = (rd_ptr != wr_ptr);
  assign has_credit = (cred_cnt != '0) || out_credit;
  assign rd_issue   = has_word && has_credit;

  // Slot is handed back as soon as its read goes out
  assign slot_freed = rd_issue;

  // --------------------------------------------------------------------------
  // Downstream credit counter
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cred_cnt <= '0;
    end else begin
      case ({out_credit, rd_issue})
        2'b10:   cred_cnt <= cred_cnt + 1'b1;
        2'b01:   cred_cnt <= cred_cnt - 1'b1;
        // Gain and spend together, or neither
        default: cred_cnt <= cred_cnt;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Read pointer
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (rd_issue) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  assign ram.rd_en   = rd_issue;
  assign ram.rd_addr = rd_ptr[SBUF_ADDR_W-1:0];

  // --------------------------------------------------------------------------
  // Output stage
  // --------------------------------------------------------------------------

  // Valid trails the issue by the RAM read latency
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= rd_issue;
    end
  end

  // RAM holds the word until the next read, no extra register needed
  assign out_data = ram.rd_data;

endmodule

/* hw/sbuf_write_ctrl.sv */
// Stream buffer write controller

`timescale 1ns/10ps

module sbuf_write_ctrl (
  input  logic            clk,
  input  logic            rst_n,
  // Upstream sender
  input  logic            in_valid,
  input  sbuf_pkg::data_t in_data,
  output logic            in_credit,
  // From the read controller
  input  logic            slot_freed,
  output sbuf_pkg::ptr_t  wr_ptr,
  // RAM write port
  ram_port_if.write_side  ram
);
  import sbuf_pkg::*;

  // Credits owed to the sender but not yet paid out
  credit_cnt_t pend_cnt;

  // One credit goes out this cycle
  logic        pay_credit;

  // --------------------------------------------------------------------------
  // Upstream credit return
  // --------------------------------------------------------------------------

  // Pay when credits are owed, or pass a freed slot straight through
  // so the return latency can be a single cycle
  assign pay_credit = (pend_cnt != '0) || slot_freed;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // Empty RAM, every slot is owed as a credit
      pend_cnt  <= credit_cnt_t'(SBUF_DEPTH);
      in_credit <= 1'b0;
    end else begin
      in_credit <= pay_credit;
      // A freed slot paid out in the same cycle leaves the count alone
      if (pay_credit && !slot_freed) begin
        pend_cnt <= pend_cnt - 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Write pointer
  // --------------------------------------------------------------------------

  // Counts words committed, wrap bit included
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (in_valid) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // RAM write port
  // --------------------------------------------------------------------------

  // Sender only sends against a credit, so the slot is always free
  assign ram.wr_en   = in_valid;
  // Low pointer bits pick the slot
  assign ram.wr_addr = wr_ptr[SBUF_ADDR_W-1:0];
  assign ram.wr_data = in_data;

endmodule

/* hw/ram_sdp.sv */
// Simple dual-port RAM

`timescale 1ns/10ps

module ram_sdp #(
  parameter int DATA_WIDTH = sbuf_pkg::SBUF_DATA_W,
  parameter int ADDR_WIDTH = sbuf_pkg::SBUF_ADDR_W
) (
  input logic     clk,
  ram_port_if.mem mem
);

  // Storage array, 2**ADDR_WIDTH words
  logic [DATA_WIDTH-1:0] ram_array [2**ADDR_WIDTH];

  // Read data register, no reset as in a block RAM
  logic [DATA_WIDTH-1:0] rd_data_q;

  // --------------------------------------------------------------------------
  // Write port
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (mem.wr_en) begin
      ram_array[mem.wr_addr] <= mem.wr_data;
    end
  end

  // --------------------------------------------------------------------------
  // Read port, one cycle latency
  // --------------------------------------------------------------------------

  // Holds its value while rd_en is low
  always_ff @(posedge clk) begin
    if (mem.rd_en) begin
      rd_data_q <= ram_array[mem.rd_addr];
    end
  end

  assign mem.rd_data = rd_data_q;

endmodule

/* hw/ram_port_if.sv */
// RAM write and read port bundle

`timescale 1ns/10ps

interface ram_port_if;
  import sbuf_pkg::*;

  // Write port, data lands on the edge where wr_en is high
  logic  wr_en;
  addr_t wr_addr;
  data_t wr_data;

  // Read port, rd_data is valid on the edge after rd_en
  logic  rd_en;
  addr_t rd_addr;
  data_t rd_data;

  // Write controller owns the write port
  modport write_side (
    output wr_en,
    output wr_addr,
    output wr_data
  );

  // Read controller issues addresses and takes the data back
  modport read_side (
    output rd_en,
    output rd_addr,
    input  rd_data
  );

  // Memory sinks both ports and returns the read word
  modport mem (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

/* hw/sbuf_pkg.sv */
// Stream buffer shared definitions

package sbuf_pkg;

  // --------------------------------------------------------------------------
  // Buffer sizes
  // --------------------------------------------------------------------------

  // Number of RAM slots
  localparam int SBUF_DEPTH  = 16;
  // Slot address width, log2 of the depth
  localparam int SBUF_ADDR_W = 4;
  // Width of one stored word
  localparam int SBUF_DATA_W = 32;

  // --------------------------------------------------------------------------
  // Vector types
  // --------------------------------------------------------------------------

  // One data word as stored in the RAM
  typedef logic [SBUF_DATA_W-1:0] data_t;

  // RAM slot address
  typedef logic [SBUF_ADDR_W-1:0] addr_t;

  // Slot address plus wrap bit, so full and empty differ
  typedef logic [SBUF_ADDR_W:0] ptr_t;

  // Credit count, holds 0 up to SBUF_DEPTH
  typedef logic [$clog2(SBUF_DEPTH+1)-1:0] credit_cnt_t;

endpackage
